//--- Makefile
VERILATOR ?= verilator
TOP       := tb_tmu
FILELIST  := compile.f
VFLAGS    := --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
OBJDIR    := obj_dir

SIM     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee /dev/stderr | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJDIR)

//--- compile.f
verilog/tmu_pkg.sv
verilog/tmu_ctl.sv
verilog/tmu_decay.sv
verilog/tmu_burst.sv
verilog/tmu_pixout.sv
verilog/tmu_top.sv
verif/tb_fml_slave.sv
verif/tb_tmu.sv

//--- verif/tb_fml_slave.sv
/*
 * FML write slave model
 * Acks each request after a random wait of 0 to 7 cycles, collects the
 * four beats and presents the whole burst for one cycle.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_fml_slave #(
	parameter int adr_w = 26
) (
	input wire sys_clk,
	input wire sys_rst,
	input wire [adr_w-1:0] fml_adr_i,
	input wire fml_stb_i,
	input wire [tmu_pkg::BEAT_SEL-1:0] fml_sel_i,
	input wire [tmu_pkg::BEAT_BITS-1:0] fml_do_i,
	output logic fml_ack_o,
	output logic cap_valid_o,
	output logic [adr_w-1:0] cap_adr_o,
	output logic [tmu_pkg::BEATS*tmu_pkg::BEAT_SEL-1:0] cap_sel_o,
	output logic [tmu_pkg::BURST_BITS-1:0] cap_data_o
);

import tmu_pkg::*;

logic [2:0] wait_cnt;
logic beat_run;
logic [1:0] beat_idx;

always @(posedge sys_clk) begin
	if (sys_rst) begin
		fml_ack_o <= 1'b0;
		cap_valid_o <= 1'b0;
		beat_run <= 1'b0;
		beat_idx <= '0;
		wait_cnt <= 3'($urandom);
	end else begin
		cap_valid_o <= 1'b0;
		if (fml_ack_o) begin
			fml_ack_o <= 1'b0;
			beat_run <= 1'b1;    // beats start next cycle
			beat_idx <= '0;
			cap_adr_o <= fml_adr_i;
			wait_cnt <= 3'($urandom);
		end else if (beat_run) begin
			cap_data_o <= {cap_data_o[BURST_BITS-BEAT_BITS-1:0], fml_do_i};
			cap_sel_o <= {cap_sel_o[(BEATS-1)*BEAT_SEL-1:0], fml_sel_i};
			beat_idx <= beat_idx + 1'b1;
			if (beat_idx == 2'd3) begin
				beat_run <= 1'b0;
				cap_valid_o <= 1'b1;    // whole burst is in
			end
		end else if (fml_stb_i) begin
			if (wait_cnt == 3'd0)
				fml_ack_o <= 1'b1;
			else
				wait_cnt <= wait_cnt - 1'b1;
		end
	end
end

endmodule

`default_nettype wire

//--- verif/tb_tmu.sv
/*
 * TMU output path testbench
 * Sends pixel runs into the DUT, models the FML bursts they should give
 * and checks each captured burst and the run control with assertions.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_tmu;

import tmu_pkg::*;

localparam int FML_DEPTH = 26;
localparam int DADR_W = FML_DEPTH - 1;
localparam int BADR_W = FML_DEPTH - 5;
localparam int BSEL_W = BEATS * BEAT_SEL;
localparam int TIMEOUT = 6 * 2000;

logic sys_clk;
logic sys_rst;
logic start, key_en, pix_stb, pix_last;
logic [BRIGHT_W-1:0] bright;
color_t key, pix_color;
logic [DADR_W-1:0] pix_dadr;
wire pix_ack, busy, irq, fml_stb, fml_ack, cap_valid;
wire [FML_DEPTH-1:0] fml_adr, cap_adr;
wire [BEAT_SEL-1:0] fml_sel;
wire [BEAT_BITS-1:0] fml_do;
wire [BSEL_W-1:0] cap_sel;
wire [BURST_BITS-1:0] cap_data;

// expected model
logic [BRIGHT_W-1:0] cfg_bright;
logic cfg_key_en;
color_t cfg_key;
logic [BADR_W-1:0] cur_badr;
logic [BURST_PIXELS-1:0] cur_sel = '0;
logic [BURST_BITS-1:0] cur_data = '0;
logic [FML_DEPTH-1:0] q_adr[$];
logic [BSEL_W-1:0] q_sel[$];
logic [BURST_BITS-1:0] q_data[$];
logic [FML_DEPTH-1:0] exp_adr;
logic [BSEL_W-1:0] exp_sel;
logic [BURST_BITS-1:0] exp_data, exp_mask;
int exp_count = 0;

color_t px_color[$];
logic [DADR_W-1:0] px_dadr[$];
int errors = 0;
int tests_failed = 0;
int cycles = 0;
int irq_count = 0;
int runs_done = 0;

tmu_top #(.fml_depth(FML_DEPTH)) uut (
	.sys_clk(sys_clk), .sys_rst(sys_rst),
	.start_i(start), .brightness_i(bright),
	.chroma_key_en_i(key_en), .chroma_key_i(key),
	.pix_stb_i(pix_stb), .pix_color_i(pix_color), .pix_dadr_i(pix_dadr),
	.pix_last_i(pix_last), .pix_ack_o(pix_ack),
	.busy_o(busy), .irq_o(irq),
	.fml_adr_o(fml_adr), .fml_stb_o(fml_stb), .fml_ack_i(fml_ack),
	.fml_sel_o(fml_sel), .fml_do_o(fml_do)
);

tb_fml_slave #(.adr_w(FML_DEPTH)) fml_slave (
	.sys_clk(sys_clk), .sys_rst(sys_rst),
	.fml_adr_i(fml_adr), .fml_stb_i(fml_stb), .fml_sel_i(fml_sel),
	.fml_do_i(fml_do), .fml_ack_o(fml_ack),
	.cap_valid_o(cap_valid), .cap_adr_o(cap_adr),
	.cap_sel_o(cap_sel), .cap_data_o(cap_data)
);

initial begin
	sys_clk = 1'b0;
	forever #10 sys_clk = ~sys_clk;
end

task automatic flag_mismatch(input string sig, input logic [255:0] got,
		input logic [255:0] exp);
	$display("mismatch %s: got %0h expected %0h", sig, got, exp);
	errors++;
endtask

task automatic report_error(input string what);
	$display("error: %s", what);
	errors++;
endtask

a_burst_expected: assert property (@(posedge sys_clk) disable iff (sys_rst)
	cap_valid |-> exp_count != 0)
	else report_error("FML burst written while none was expected");
a_burst_adr: assert property (@(posedge sys_clk) disable iff (sys_rst)
	cap_valid && exp_count != 0 |-> cap_adr == exp_adr)
	else flag_mismatch("fml_adr_o", cap_adr, exp_adr);
a_burst_sel: assert property (@(posedge sys_clk) disable iff (sys_rst)
	cap_valid && exp_count != 0 |-> cap_sel == exp_sel)
	else flag_mismatch("fml_sel_o", cap_sel, exp_sel);
a_burst_data: assert property (@(posedge sys_clk) disable iff (sys_rst)
	cap_valid && exp_count != 0 |-> (cap_data & exp_mask) == exp_data)
	else flag_mismatch("fml_do_o", cap_data & exp_mask, exp_data);
a_ack_in_run: assert property (@(posedge sys_clk) disable iff (sys_rst)
	pix_ack |-> busy)
	else report_error("pix_ack_o high while the unit was idle");
a_busy_rise: assert property (@(posedge sys_clk) disable iff (sys_rst)
	start && !busy |=> busy)
	else report_error("busy_o did not rise after start_i");
a_irq_idle: assert property (@(posedge sys_clk) disable iff (sys_rst)
	irq |-> !busy && exp_count == 0)
	else report_error("irq_o raised before the run was fully written");
a_busy_fall: assert property (@(posedge sys_clk) disable iff (sys_rst)
	$fell(busy) |-> irq)
	else report_error("busy_o fell without an irq_o pulse");
a_flush_state: assert property (@(posedge sys_clk) disable iff (sys_rst)
	uut.ctl.state == ST_FLUSH |=> uut.ctl.state == ST_WAIT_FLUSH)
	else report_error("control FSM stayed in the flush state");

// queue head, settled mid-cycle for the checks at the next edge
always @(negedge sys_clk) begin
	exp_count = q_adr.size();
	exp_adr = (exp_count != 0) ? q_adr[0] : '0;
	exp_sel = (exp_count != 0) ? q_sel[0] : '0;
	exp_data = (exp_count != 0) ? q_data[0] : '0;
	for (int b = 0; b < BSEL_W; b++)
		exp_mask[8*b +: 8] = {8{exp_sel[b]}};
end

always @(posedge sys_clk) begin
	if (!sys_rst && cap_valid && q_adr.size() != 0) begin
		void'(q_adr.pop_front());
		void'(q_sel.pop_front());
		void'(q_data.pop_front());
	end
end

always @(posedge sys_clk) begin
	cycles <= cycles + 1;
	if (!sys_rst && irq)
		irq_count <= irq_count + 1;
	if (cycles >= TIMEOUT) begin
		$display("timeout: run did not finish within %0d cycles", TIMEOUT);
		$display("=== FAIL ===");
		$finish;
	end
end

function automatic color_t scale_color(input color_t c, input logic [BRIGHT_W-1:0] lvl);
	int m, r, g, bl;
	m = int'(lvl) + 1;
	r = (int'(c[15:11]) * m) >> 6;
	g = (int'(c[10:5]) * m) >> 6;
	bl = (int'(c[4:0]) * m) >> 6;
	return {5'(r), 6'(g), 5'(bl)};
endfunction

task automatic push_burst();
	logic [BSEL_W-1:0] bsel;
	bsel = '0;
	for (int s = 0; s < BURST_PIXELS; s++)
		if (cur_sel[BURST_PIXELS-1-s])
			bsel[BSEL_W-1-2*s -: 2] = 2'b11;    // slot 0 leads
	q_adr.push_back({cur_badr, 5'd0});
	q_sel.push_back(bsel);
	q_data.push_back(cur_data);
	cur_sel = '0;
	cur_data = '0;
endtask

task automatic model_pixel(input color_t c, input logic [DADR_W-1:0] a);
	int slot;
	slot = int'(a[PIX_IDX_W-1:0]);
	if (cfg_key_en && c == cfg_key)
		return;    // keyed, never reaches memory
	if (cur_sel != '0 && a[DADR_W-1:PIX_IDX_W] != cur_badr)
		push_burst();
	cur_badr = a[DADR_W-1:PIX_IDX_W];
	cur_sel[BURST_PIXELS-1-slot] = 1'b1;
	cur_data[BURST_BITS-1-16*slot -: 16] = scale_color(c, cfg_bright);
endtask

task automatic add_pixel(input color_t c, input logic [BADR_W-1:0] ba,
		input logic [PIX_IDX_W-1:0] slot);
	px_color.push_back(c);
	px_dadr.push_back({ba, slot});
endtask

task automatic configure(input logic [BRIGHT_W-1:0] lvl, input logic en, input color_t k);
	@(posedge sys_clk);
	cfg_bright = lvl;
	cfg_key_en = en;
	cfg_key = k;
	bright <= lvl;
	key_en <= en;
	key <= k;
endtask

task automatic wait_irq();
	int n;
	n = 0;
	@(negedge sys_clk);
	while (!irq && n < 2000) begin
		@(negedge sys_clk);
		n++;
	end
	runs_done++;
	if (!irq)
		report_error("irq_o did not pulse at the end of the run");
	repeat (2) @(negedge sys_clk);
	assert (irq_count == runs_done)
		else report_error($sformatf("irq_o pulsed %0d times over %0d runs",
			irq_count, runs_done));
endtask

task automatic send_run();
	int n;
	n = px_color.size();
	@(posedge sys_clk);
	start <= 1'b1;
	@(posedge sys_clk);
	start <= 1'b0;
	for (int i = 0; i < n; i++) begin
		pix_stb <= 1'b1;
		pix_color <= px_color[i];
		pix_dadr <= px_dadr[i];
		pix_last <= (i == n - 1);
		do @(negedge sys_clk); while (!pix_ack);    // taken at next edge
		@(posedge sys_clk);
		model_pixel(px_color[i], px_dadr[i]);
	end
	pix_stb <= 1'b0;
	pix_last <= 1'b0;
	if (cur_sel != '0)
		push_burst();    // flushed partial burst
	wait_irq();
	px_color.delete();
	px_dadr.delete();
endtask

task automatic end_test(input int num, input string name, input int errs_before);
	$display("test %0d %s: %s", num, name, (errors == errs_before) ? "ok" : "FAILED");
	if (errors != errs_before)
		tests_failed++;
endtask

initial begin
	logic [BADR_W-1:0] badr;
	int errs0, cnt;
	void'($urandom(32'hbec0));
	sys_rst = 1'b1;
	start <= 1'b0;
	bright <= '1;
	key_en <= 1'b0;
	key <= '0;
	pix_stb <= 1'b0;
	pix_color <= '0;
	pix_dadr <= '0;
	pix_last <= 1'b0;
	repeat (16) @(posedge sys_clk);
	sys_rst <= 1'b0;

	errs0 = errors;
	@(negedge sys_clk);
	assert (!busy) else flag_mismatch("busy_o", busy, 0);
	assert (!irq) else flag_mismatch("irq_o", irq, 0);
	assert (!fml_stb) else flag_mismatch("fml_stb_o", fml_stb, 0);
	assert (!pix_ack) else flag_mismatch("pix_ack_o", pix_ack, 0);
	@(posedge sys_clk);
	pix_stb <= 1'b1;    // offered but never started
	repeat (20) begin
		@(negedge sys_clk);
		assert (!pix_ack) else flag_mismatch("pix_ack_o", pix_ack, 0);
	end
	@(posedge sys_clk);
	pix_stb <= 1'b0;
	end_test(1, "reset and idle", errs0);

	errs0 = errors;
	configure(6'd63, 1'b0, '0);
	for (int s = 0; s < BURST_PIXELS; s++)
		add_pixel(16'($urandom), 21'h01234, 4'(s));
	send_run();
	end_test(2, "full burst at unity brightness", errs0);

	errs0 = errors;
	for (int r = 0; r < 4; r++) begin
		configure(6'($urandom), 1'b0, '0);
		badr = BADR_W'($urandom);
		for (int s = 0; s < BURST_PIXELS; s++)
			add_pixel(16'($urandom), badr, 4'(s));
		send_run();
	end
	end_test(3, "brightness scaling", errs0);

	errs0 = errors;
	configure(6'd40, 1'b1, 16'hf81f);
	for (int i = 0; i < 32; i++)
		add_pixel(($urandom % 3 == 0) ? 16'hf81f : 16'($urandom),
			21'h00200 + 21'(i / 16), 4'(i));
	send_run();
	for (int i = 0; i < 8; i++)
		add_pixel(16'hf81f, 21'h00300, 4'(i));
	send_run();
	end_test(4, "chroma keying", errs0);

	errs0 = errors;
	configure(6'd63, 1'b0, '0);
	for (int i = 0; i < 6; i++)
		add_pixel(16'($urandom), 21'h00100, 4'($urandom));
	for (int i = 0; i < 5; i++)
		add_pixel(16'($urandom), 21'h00101, 4'($urandom));
	for (int i = 0; i < 3; i++)
		add_pixel(16'($urandom), 21'h1ffff, 4'($urandom));
	send_run();
	end_test(5, "scattered bursts and partial flush", errs0);

	errs0 = errors;
	for (int r = 0; r < 2; r++) begin
		configure(6'($urandom), 1'b0, '0);
		for (int b = 0; b < 40; b++) begin
			badr = BADR_W'($urandom);
			cnt = 1 + $urandom % 8;
			for (int i = 0; i < cnt; i++)
				add_pixel(16'($urandom), badr, 4'($urandom));
		end
		send_run();
	end
	end_test(6, "long runs under random ack delay", errs0);

	$display("tests 6, failed %0d, errors %0d", tests_failed, errors);
	if (errors == 0)
		$display("=== PASS ===");
	else
		$display("=== FAIL ===");
	$finish;
end

endmodule

`default_nettype wire

//--- verilog/tmu_burst.sv
/*
 * TMU burst assembler
 * Gathers the pixels of one 32-byte burst into a 256-bit line with a
 * per-pixel select mask and hands full or flushed lines to the writer.
 */

`timescale 1ns/1ps
`default_nettype none

module tmu_burst #(
	parameter int fml_depth = 26
) (
	input wire sys_clk,
	input wire sys_rst,

	input wire flush_i,

	input wire pipe_stb_i,
	input wire tmu_pkg::color_t pipe_color_i,
	input wire [fml_depth-2:0] pipe_dadr_i,
	output logic pipe_ack_o,

	output logic pipe_stb_o,
	output logic [fml_depth-6:0] burst_addr_o,
	output logic [tmu_pkg::BURST_PIXELS-1:0] burst_sel_o,
	output logic [tmu_pkg::BURST_BITS-1:0] burst_data_o,
	input wire pipe_ack_i,

	output logic busy_o
);

import tmu_pkg::*;

localparam int CW = $bits(color_t);

logic [BURST_BITS-1:0] line_q;
logic [BURST_PIXELS-1:0] sel_q;
logic [fml_depth-6:0] addr_q;

logic [PIX_IDX_W-1:0] slot;
logic [fml_depth-6:0] in_addr;
logic [BURST_PIXELS-1:0] slot_bit;
logic pending;
logic new_burst;
logic out_free;
logic accept;
logic handoff;

assign slot = pipe_dadr_i[PIX_IDX_W-1:0];
assign in_addr = pipe_dadr_i[fml_depth-2:PIX_IDX_W];

// slot 0 sits in the most significant bits
always_comb begin
	slot_bit = '0;
	slot_bit[BURST_PIXELS-1-slot] = 1'b1;
end

assign pending = |sel_q;
assign new_burst = pending && (in_addr != addr_q);
assign out_free = !pipe_stb_o || pipe_ack_i;

// a pixel of another burst needs room in the output register first
assign pipe_ack_o = !flush_i && (!new_burst || out_free);
assign accept = pipe_stb_i && pipe_ack_o;

assign handoff = (accept && new_burst) || (flush_i && pending && out_free);

always_ff @(posedge sys_clk) begin
	if (sys_rst) begin
		sel_q <= '0;
	end else if (accept) begin
		sel_q <= new_burst ? slot_bit : (sel_q | slot_bit);
	end else if (handoff) begin
		sel_q <= '0;    // flushed, line empty again
	end
end

always_ff @(posedge sys_clk) begin
	if (accept) begin
		line_q[BURST_BITS-1-slot*CW -: CW] <= pipe_color_i;
		addr_q <= in_addr;
	end
end

always_ff @(posedge sys_clk) begin
	if (sys_rst)
		pipe_stb_o <= 1'b0;
	else if (handoff)
		pipe_stb_o <= 1'b1;
	else if (pipe_ack_i)
		pipe_stb_o <= 1'b0;
end

// stale slots of the old line are masked off by sel
always_ff @(posedge sys_clk) begin
	if (handoff) begin
		burst_addr_o <= addr_q;
		burst_sel_o <= sel_q;
		burst_data_o <= line_q;
	end
end

assign busy_o = pending || pipe_stb_o;

a_sel_nonzero: assert property (@(posedge sys_clk) disable iff (sys_rst)
	pipe_stb_o |-> (burst_sel_o != '0))
	else $error("burst issued with an empty select mask");

// run control only flushes once the writer has room
a_flush_room: assert property (@(posedge sys_clk) disable iff (sys_rst)
	flush_i && pending |-> out_free)
	else $error("flush arrived while the output register was blocked");

endmodule

`default_nettype wire

//--- verilog/tmu_ctl.sv
/*
 * TMU run control
 * Gates the pixel input for one run, flushes the burst assembler once the
 * last pixel has gone through and raises the completion interrupt.
 */

`timescale 1ns/1ps
`default_nettype none

module tmu_ctl (
	input wire sys_clk,
	input wire sys_rst,

	input wire start_i,
	input wire pix_stb_i,
	input wire pix_last_i,
	input wire pix_ack_i,

	input wire decay_busy_i,
	input wire burst_busy_i,
	input wire pixout_busy_i,

	output logic run_o,
	output logic flush_o,
	output logic busy_o,
	output logic irq_o
);

import tmu_pkg::*;

ctl_state_t state;
ctl_state_t next_state;

always_ff @(posedge sys_clk) begin
	if (sys_rst)
		state <= ST_IDLE;
	else
		state <= next_state;
end

// input window of the run, closes on the accepted last pixel
always_ff @(posedge sys_clk) begin
	if (sys_rst)
		run_o <= 1'b0;
	else if ((state == ST_IDLE) && start_i)
		run_o <= 1'b1;
	else if (pix_stb_i && pix_ack_i && pix_last_i)
		run_o <= 1'b0;
end

always_comb begin
	next_state = state;
	flush_o = 1'b0;
	case (state)
		ST_IDLE: begin
			if (start_i)
				next_state = ST_WAIT_PROCESS;
		end
		ST_WAIT_PROCESS: begin
			// burst may still hold pending slots here, the flush drains them
			if (!run_o && !decay_busy_i && !pixout_busy_i)
				next_state = ST_FLUSH;
		end
		ST_FLUSH: begin
			flush_o = 1'b1;
			next_state = ST_WAIT_FLUSH;
		end
		ST_WAIT_FLUSH: begin
			if (!decay_busy_i && !burst_busy_i && !pixout_busy_i)
				next_state = ST_IDLE;
		end
		default: next_state = ST_IDLE;
	endcase
end

assign busy_o = (state != ST_IDLE);

// lands on the first idle cycle, when busy_o drops
always_ff @(posedge sys_clk) begin
	if (sys_rst)
		irq_o <= 1'b0;
	else
		irq_o <= (state == ST_WAIT_FLUSH) && (next_state == ST_IDLE);
end

a_flush_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst)
	flush_o |=> !flush_o)
	else $error("flush_o held longer than one cycle");

a_irq_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst)
	irq_o |=> !irq_o)
	else $error("irq_o high in two consecutive cycles");

endmodule

`default_nettype wire

//--- verilog/tmu_decay.sv
/*
 * TMU decay stage
 * Scales each colour channel by the brightness level and drops pixels
 * that match the chroma key. One register of latency.
 */

`timescale 1ns/1ps
`default_nettype none

module tmu_decay #(
	parameter int fml_depth = 26
) (
	input wire sys_clk,
	input wire sys_rst,

	input wire run_i,

	input wire [tmu_pkg::BRIGHT_W-1:0] brightness_i,
	input wire chroma_key_en_i,
	input wire tmu_pkg::color_t chroma_key_i,

	input wire pipe_stb_i,
	input wire tmu_pkg::color_t pipe_color_i,
	input wire [fml_depth-2:0] pipe_dadr_i,
	output logic pipe_ack_o,

	output logic pipe_stb_o,
	output tmu_pkg::color_t pipe_color_o,
	output logic [fml_depth-2:0] pipe_dadr_o,
	input wire pipe_ack_i,

	output logic busy_o
);

import tmu_pkg::*;

logic [BRIGHT_W:0] mult;
logic [11:0] r_prod;
logic [12:0] g_prod;
logic [11:0] b_prod;
color_t scaled;
logic keyed;
logic accept;

// brightness+1 so that level 63 is unity gain
assign mult = {1'b0, brightness_i} + 1'b1;

assign r_prod = pipe_color_i[15:11] * mult;
assign g_prod = pipe_color_i[10:5] * mult;
assign b_prod = pipe_color_i[4:0] * mult;

assign scaled = {r_prod[10:6], g_prod[11:6], b_prod[10:6]};

// key compares the colour before scaling
assign keyed = chroma_key_en_i && (pipe_color_i == chroma_key_i);

// take a pixel only while the run is open and the register can drain
assign pipe_ack_o = run_i && (!pipe_stb_o || pipe_ack_i);
assign accept = pipe_stb_i && pipe_ack_o;

always_ff @(posedge sys_clk) begin
	if (sys_rst)
		pipe_stb_o <= 1'b0;
	else if (accept)
		pipe_stb_o <= !keyed;    // keyed pixel is swallowed
	else if (pipe_ack_i)
		pipe_stb_o <= 1'b0;
end

always_ff @(posedge sys_clk) begin
	if (accept && !keyed) begin
		pipe_color_o <= scaled;
		pipe_dadr_o <= pipe_dadr_i;
	end
end

assign busy_o = pipe_stb_o;

a_out_stable: assert property (@(posedge sys_clk) disable iff (sys_rst)
	pipe_stb_o && !pipe_ack_i |=>
		pipe_stb_o && $stable(pipe_color_o) && $stable(pipe_dadr_o))
	else $error("decay output changed while waiting for ack");

endmodule

`default_nettype wire

//--- verilog/tmu_pixout.sv
/*
 * TMU pixel output
 * FML write master. Requests one burst address and streams the line as
 * four 64-bit beats with byte selects.
 */

`timescale 1ns/1ps
`default_nettype none

module tmu_pixout #(
	parameter int fml_depth = 26
) (
	input wire sys_clk,
	input wire sys_rst,

	input wire pipe_stb_i,
	input wire [fml_depth-6:0] burst_addr_i,
	input wire [tmu_pkg::BURST_PIXELS-1:0] burst_sel_i,
	input wire [tmu_pkg::BURST_BITS-1:0] burst_data_i,
	output logic pipe_ack_o,

	output logic [fml_depth-1:0] fml_adr_o,
	output logic fml_stb_o,
	input wire fml_ack_i,
	output logic [tmu_pkg::BEAT_SEL-1:0] fml_sel_o,
	output logic [tmu_pkg::BEAT_BITS-1:0] fml_do_o,

	output logic busy_o
);

import tmu_pkg::*;

localparam int PIX_PER_BEAT = BEAT_BITS / $bits(color_t);
localparam int CNT_W = $clog2(BEATS);

logic [fml_depth-6:0] addr_q;
logic [BURST_PIXELS-1:0] sel_q;
logic [BURST_BITS-1:0] data_q;
logic beat_run;
logic [CNT_W-1:0] beat_cnt;
logic accept;

assign busy_o = fml_stb_o || beat_run;
assign pipe_ack_o = !busy_o;
assign accept = pipe_stb_i && pipe_ack_o;

always_ff @(posedge sys_clk) begin
	if (sys_rst) begin
		fml_stb_o <= 1'b0;
		beat_run <= 1'b0;
		beat_cnt <= '0;
	end else begin
		if (accept)
			fml_stb_o <= 1'b1;
		else if (fml_stb_o && fml_ack_i)
			fml_stb_o <= 1'b0;

		if (fml_stb_o && fml_ack_i) begin
			beat_run <= 1'b1;    // data starts the cycle after ack
			beat_cnt <= '0;
		end else if (beat_run) begin
			beat_cnt <= beat_cnt + 1'b1;
			if (beat_cnt == CNT_W'(BEATS - 1))
				beat_run <= 1'b0;
		end
	end
end

// line shifts up one beat at a time, MS slice goes out first
always_ff @(posedge sys_clk) begin
	if (accept) begin
		addr_q <= burst_addr_i;
		sel_q <= burst_sel_i;
		data_q <= burst_data_i;
	end else if (beat_run) begin
		sel_q <= sel_q << PIX_PER_BEAT;
		data_q <= data_q << BEAT_BITS;
	end
end

assign fml_adr_o = {addr_q, 5'd0};
assign fml_do_o = data_q[BURST_BITS-1 -: BEAT_BITS];

// two byte selects per pixel
always_comb begin
	for (int i = 0; i < PIX_PER_BEAT; i++)
		fml_sel_o[2*i +: 2] = {2{sel_q[BURST_PIXELS-PIX_PER_BEAT+i]}};
end

a_stb_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
	fml_stb_o && !fml_ack_i |=> fml_stb_o && $stable(fml_adr_o))
	else $error("fml_stb_o dropped without fml_ack_i");

endmodule

`default_nettype wire

//--- verilog/tmu_pkg.sv
/*
 * TMU shared definitions
 * Pixel colour type, run-control states and the burst geometry of the
 * FML write path.
 */

`default_nettype none

package tmu_pkg;

	// RGB565 pixel: red 15..11, green 10..5, blue 4..0
	typedef logic [15:0] color_t;

	// run-control FSM states
	typedef enum logic [1:0] {
		ST_IDLE         = 2'd0,
		ST_WAIT_PROCESS = 2'd1,
		ST_FLUSH        = 2'd2,
		ST_WAIT_FLUSH   = 2'd3
	} ctl_state_t;

	localparam int BRIGHT_W = 6;        // brightness level 0..63

	// one FML burst is 32 bytes, i.e. 16 RGB565 pixels
	localparam int BURST_PIXELS = 16;
	localparam int BURST_BITS = 256;

	// the burst goes out as four 64-bit beats
	localparam int BEATS = 4;
	localparam int BEAT_BITS = 64;
	localparam int BEAT_SEL = 8;        // byte selects per beat

	localparam int PIX_IDX_W = 4;       // pixel slot inside a burst

endpackage

`default_nettype wire

//--- verilog/tmu_top.sv
/*
 * TMU output path
 * Run control, decay stage, burst assembler and FML writer.
 */

`timescale 1ns/1ps
`default_nettype none

module tmu_top #(
	parameter int fml_depth = 26
) (
	input wire sys_clk,
	input wire sys_rst,

	input wire start_i,
	input wire [tmu_pkg::BRIGHT_W-1:0] brightness_i,
	input wire chroma_key_en_i,
	input wire tmu_pkg::color_t chroma_key_i,

	input wire pix_stb_i,
	input wire tmu_pkg::color_t pix_color_i,
	input wire [fml_depth-2:0] pix_dadr_i,
	input wire pix_last_i,
	output wire pix_ack_o,

	output wire busy_o,
	output wire irq_o,

	output wire [fml_depth-1:0] fml_adr_o,
	output wire fml_stb_o,
	input wire fml_ack_i,
	output wire [tmu_pkg::BEAT_SEL-1:0] fml_sel_o,
	output wire [tmu_pkg::BEAT_BITS-1:0] fml_do_o
);

import tmu_pkg::*;

wire run;
wire flush;
wire decay_busy;
wire burst_busy;
wire pixout_busy;

// decay to burst
wire decay_stb;
wire decay_ack;
color_t decay_color;
wire [fml_depth-2:0] decay_dadr;

// burst to pixout
wire burst_stb;
wire burst_ack;
wire [fml_depth-6:0] burst_addr;
wire [BURST_PIXELS-1:0] burst_sel;
wire [BURST_BITS-1:0] burst_data;

tmu_ctl ctl (
	.sys_clk(sys_clk),
	.sys_rst(sys_rst),
	.start_i(start_i),
	.pix_stb_i(pix_stb_i),
	.pix_last_i(pix_last_i),
	.pix_ack_i(pix_ack_o),
	.decay_busy_i(decay_busy),
	.burst_busy_i(burst_busy),
	.pixout_busy_i(pixout_busy),
	.run_o(run),
	.flush_o(flush),
	.busy_o(busy_o),
	.irq_o(irq_o)
);

tmu_decay #(
	.fml_depth(fml_depth)
) decay (
	.sys_clk(sys_clk),
	.sys_rst(sys_rst),
	.run_i(run),
	.brightness_i(brightness_i),
	.chroma_key_en_i(chroma_key_en_i),
	.chroma_key_i(chroma_key_i),
	.pipe_stb_i(pix_stb_i),
	.pipe_color_i(pix_color_i),
	.pipe_dadr_i(pix_dadr_i),
	.pipe_ack_o(pix_ack_o),
	.pipe_stb_o(decay_stb),
	.pipe_color_o(decay_color),
	.pipe_dadr_o(decay_dadr),
	.pipe_ack_i(decay_ack),
	.busy_o(decay_busy)
);

tmu_burst #(
	.fml_depth(fml_depth)
) burst (
	.sys_clk(sys_clk),
	.sys_rst(sys_rst),
	.flush_i(flush),
	.pipe_stb_i(decay_stb),
	.pipe_color_i(decay_color),
	.pipe_dadr_i(decay_dadr),
	.pipe_ack_o(decay_ack),
	.pipe_stb_o(burst_stb),
	.burst_addr_o(burst_addr),
	.burst_sel_o(burst_sel),
	.burst_data_o(burst_data),
	.pipe_ack_i(burst_ack),
	.busy_o(burst_busy)
);

tmu_pixout #(
	.fml_depth(fml_depth)
) pixout (
	.sys_clk(sys_clk),
	.sys_rst(sys_rst),
	.pipe_stb_i(burst_stb),
	.burst_addr_i(burst_addr),
	.burst_sel_i(burst_sel),
	.burst_data_i(burst_data),
	.pipe_ack_o(burst_ack),
	.fml_adr_o(fml_adr_o),
	.fml_stb_o(fml_stb_o),
	.fml_ack_i(fml_ack_i),
	.fml_sel_o(fml_sel_o),
	.fml_do_o(fml_do_o),
	.busy_o(pixout_busy)
);

endmodule

`default_nettype wire
